//--- dv/cpuCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuCore_config.svh"

module cpuCoreTb;

  localparam int ResetCycles = 16;
  localparam int HoldCycles  = 16;             // Watch window once hlt is up
  localparam int ProgWords   = 49;
  localparam int CycleLimit  = 8 * ProgWords + ResetCycles;  // Roughly 400
  localparam int NumStores   = 14;
  localparam logic [`CPU_DATA_W-1:0] JalAddr  = 16'h0024;
  localparam logic [`CPU_DATA_W-1:0] HaltAddr = 16'h0029;

  logic                   clk;
  logic                   arstN;
  logic [`CPU_DATA_W-1:0] imemAddr;
  logic [`CPU_DATA_W-1:0] imemData;
  logic [`CPU_DATA_W-1:0] dmemAddr;
  logic [`CPU_DATA_W-1:0] dmemWrData;
  logic                   dmemWrEn;
  logic                   dmemRdEn;
  logic [`CPU_DATA_W-1:0] dmemRdData;
  logic [`CPU_DATA_W-1:0] pc;
  logic                   hlt;

  // 256-word memory models
  logic [`CPU_DATA_W-1:0]   imem [256];
  logic [`CPU_DATA_W-1:0]   dmem [256];
  logic [`CPU_DATA_W-1:0]   preset [4];        // Words at 0x40..0x43
  logic [2*`CPU_DATA_W-1:0] wrLog [$];         // {addr, data} per write

  // Expected stores in program order
  logic [`CPU_DATA_W-1:0] expAddr [NumStores];
  logic [`CPU_DATA_W-1:0] expData [NumStores];
  string                  testName [NumStores];
  logic [`CPU_DATA_W-1:0] curAddr;
  logic [`CPU_DATA_W-1:0] curData;
  int                     tableLen = 0;
  int                     storeIdx = 0;        // Next entry due
  int unsigned            cycleCnt = 0;
  integer                 seed;
  logic                   haltSeen = 1'b0;     // Sticky copy of hlt

  int storeErrors = 0;
  int loadErrors  = 0;
  int resetErrors = 0;
  int haltErrors  = 0;
  int endErrors   = 0;

  cpuCore UUT (
    .clk        (clk),
    .arstN      (arstN),
    .imemAddr   (imemAddr),
    .imemData   (imemData),
    .dmemAddr   (dmemAddr),
    .dmemWrData (dmemWrData),
    .dmemWrEn   (dmemWrEn),
    .dmemRdEn   (dmemRdEn),
    .dmemRdData (dmemRdData),
    .pc         (pc),
    .hlt        (hlt)
  );

  initial begin : clockGen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////
  assign imemData   = imem[imemAddr[7:0]];     // Same-cycle reads
  assign dmemRdData = dmemRdEn ? dmem[dmemAddr[7:0]] : '0;  // Data only on a read

  always @(posedge clk) begin
    if (dmemWrEn) begin
      dmem[dmemAddr[7:0]] <= dmemWrData;
      wrLog.push_back({dmemAddr, dmemWrData});
      storeIdx <= storeIdx + 1;
    end
  end

  always @(posedge clk) begin
    if (hlt) begin
      haltSeen <= 1'b1;
    end
  end

  assign curAddr = (storeIdx < NumStores) ? expAddr[storeIdx] : '0;
  assign curData = (storeIdx < NumStores) ? expData[storeIdx] : '0;

  task automatic expectStore(input logic [`CPU_DATA_W-1:0] addr,
                             input logic [`CPU_DATA_W-1:0] data,
                             input string name);
    expAddr[tableLen]  = addr;
    expData[tableLen]  = data;
    testName[tableLen] = name;
    tableLen++;
  endtask

  // Store bases R13 = 0x50 and R12 = 0x60 plus the SW offsets
  // R1 = 0x0035 and R2 = 0xFFF3 from the two LLBs
  task automatic buildTable();
    expectStore(16'h0050, 16'h0028, "alu_add");   // Wraps past 0xFFFF
    expectStore(16'h0051, 16'h0042, "alu_sub");
    expectStore(16'h0052, 16'h0031, "alu_and");
    expectStore(16'h0053, 16'h0008, "alu_nor");
    expectStore(16'h0054, preset[0] + 16'h0011, "load_add_0");
    expectStore(16'h0055, preset[3] + 16'h0011, "load_add_3");
    expectStore(16'h0060, 16'h0028, "beq_slot_1");   // Three delay slots
    expectStore(16'h0061, 16'h0042, "beq_slot_2");
    expectStore(16'h0062, 16'h0031, "beq_slot_3");
    expectStore(16'h0063, 16'h0035, "bne_slot");
    expectStore(16'h0064, 16'hFFF3, "bne_fallthru");  // Only if BNE falls through
    expectStore(16'h0066, JalAddr + 1'b1, "jal_link");
    expectStore(16'h0056, 16'h0035, "jr_slot");
    expectStore(16'h0057, 16'hFFF3, "jr_return");
  endtask

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////
  // pc still unknown before the first edge
  resetState: assert property (@(posedge clk)
      (cycleCnt > 0 && (!arstN || $rose(arstN)))
      |-> (pc == '0 && !dmemWrEn && !dmemRdEn && !hlt))
    else begin
      resetErrors++;
      $display("Error reset: expected pc 0 wr 0 rd 0 hlt 0, actual pc %0h wr %b rd %b hlt %b",
               $sampled(pc), $sampled(dmemWrEn), $sampled(dmemRdEn), $sampled(hlt));
    end

  storeInTable: assert property (@(posedge clk) disable iff (!arstN)
      dmemWrEn |-> (storeIdx < NumStores))
    else begin
      storeErrors++;
      $display("Store to 0x%04h came after the last expected store", $sampled(dmemAddr));
    end

  storeAddrOk: assert property (@(posedge clk) disable iff (!arstN)
      (dmemWrEn && storeIdx < NumStores) |-> (dmemAddr == curAddr))
    else begin
      storeErrors++;
      $display("Error %s: address expected 0x%04h, actual 0x%04h",
               testName[$sampled(storeIdx)], $sampled(curAddr), $sampled(dmemAddr));
    end

  storeDataOk: assert property (@(posedge clk) disable iff (!arstN)
      (dmemWrEn && storeIdx < NumStores) |-> (dmemWrData == curData))
    else begin
      storeErrors++;
      $display("Error %s: data expected 0x%04h, actual 0x%04h",
               testName[$sampled(storeIdx)], $sampled(curData), $sampled(dmemWrData));
    end

  // Only the two LW words read memory
  loadAddrOk: assert property (@(posedge clk) disable iff (!arstN)
      dmemRdEn |-> (dmemAddr == 16'h0040 || dmemAddr == 16'h0043))
    else begin
      loadErrors++;
      $display("Error load_addr: expected 0x0040 or 0x0043, actual 0x%04h",
               $sampled(dmemAddr));
    end

  // Sticky halt with pc parked on the HLT word
  haltHold: assert property (@(posedge clk) disable iff (!arstN)
      hlt |=> (hlt && pc == HaltAddr))
    else begin
      haltErrors++;
      $display("Error halt_hold: expected pc 0x%04h hlt 1, actual pc 0x%04h hlt %b",
               HaltAddr, $sampled(pc), $sampled(hlt));
    end

  haltNoWrite: assert property (@(posedge clk) disable iff (!arstN)
      haltSeen |-> !dmemWrEn)
    else begin
      haltErrors++;
      $display("Error halt_write: expected dmemWrEn 0, actual 1 at 0x%04h",
               $sampled(dmemAddr));
    end

  // Run limit
  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt == CycleLimit) begin
      $display("Timeout, hlt did not rise within %0d cycles", CycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin : mainSeq
    int i;
    arstN = 1'b0;
    seed  = 71177;
    for (i = 0; i < 256; i++) begin
      dmem[i] = {i[7:0], ~i[7:0]};             // Unique per address
    end
    for (i = 0; i < 4; i++) begin
      preset[i]      = 16'($random(seed));
      dmem[8'h40 + i] = preset[i];
    end
    $readmemh("dv/program.hex", imem);
    buildTable();

    repeat (ResetCycles) @(posedge clk);
    arstN <= 1'b1;

    wait (hlt === 1'b1);
    repeat (HoldCycles) @(posedge clk);

    allStoresSeen: assert (wrLog.size() == tableLen)
      else begin
        endErrors++;
        $display("Saw %0d stores by the end of the run, expected %0d", wrLog.size(), tableLen);
      end

    $display("Errors: store %0d, load %0d, reset %0d, halt %0d, end %0d",
             storeErrors, loadErrors, resetErrors, haltErrors, endErrors);
    if (storeErrors + loadErrors + resetErrors + haltErrors + endErrors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/program.hex
// Program words in address order, several words per line
// Trailing note gives the hex address of the first word on the line, then the instructions
4135 42F3 4D50 4C60   // 00 LLB R1,0x35  LLB R2,0xF3  LLB R13,0x50  LLB R12,0x60
0312 1412 2512 3612   // 04 ADD R3  SUB R4  AND R5  NOR R6, all on R1 and R2
93D0 94D1 95D2 96D3   // 08 SW R3..R6 to 0x50..0x53
4740 4811 7000        // 0C LLB R7,0x40  LLB R8,0x11  NOP
8970 8A73 7000        // 0F LW R9,[R7+0]  LW R10,[R7+3]  NOP
0998 0AA8 7000        // 12 ADD R9,R9,R8  ADD R10,R10,R8  NOP
99D4 9AD5             // 15 SW R9 to 0x54  SW R10 to 0x55
1011 C205             // 17 SUB R0,R1,R1  BEQ +5 to 0x1E
93C0 94C1 95C2        // 19 delay slots, SW to 0x60..0x62
96C7 91C7             // 1C skipped by BEQ, SW to 0x67
1011 C004             // 1E SUB R0,R1,R1  BNE +4, not taken
91C3 7000 7000        // 20 delay slot SW to 0x63, NOPs
92C4                  // 23 fall-through SW to 0x64
D007 7000 7000 7000   // 24 JAL +7 to 0x2C, NOP slots, JR lands at 0x25
92D7 F000             // 28 SW R2 to 0x57  HLT
91C7 7000             // 2A after HLT, SW must be suppressed
9FC6 E0F0             // 2C SW R15 to 0x66  JR R15
91D6 7000 7000        // 2E delay slot SW to 0x56, NOPs

//--- logic/cpuCore.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuCore_config.svh"

module cpuCore import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   arstN,
  output logic [`CPU_DATA_W-1:0] imemAddr,
  input  logic [`CPU_DATA_W-1:0] imemData,
  output logic [`CPU_DATA_W-1:0] dmemAddr,
  output logic [`CPU_DATA_W-1:0] dmemWrData,
  output logic                   dmemWrEn,
  output logic                   dmemRdEn,
  input  logic [`CPU_DATA_W-1:0] dmemRdData,
  output logic [`CPU_DATA_W-1:0] pc,
  output logic                   hlt
);

  // Stage boundary bundles
  ifIdT     ifId;
  idExT     idEx;
  exMemT    exMem;
  wbT       wb;         // Back to the register file
  redirectT redirect;   // Back to fetch

  fetchStage uFetch (
    .clk      (clk),
    .arstN    (arstN),
    .redirect (redirect),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .ifId     (ifId),
    .pc       (pc)
  );

  decodeStage uDecode (
    .clk   (clk),
    .arstN (arstN),
    .ifId  (ifId),
    .wb    (wb),
    .idEx  (idEx)
  );

  executeStage uExecute (
    .clk   (clk),
    .arstN (arstN),
    .idEx  (idEx),
    .exMem (exMem)
  );

  memStage uMem (
    .clk        (clk),
    .arstN      (arstN),
    .exMem      (exMem),
    .dmemAddr   (dmemAddr),
    .dmemWrData (dmemWrData),
    .dmemWrEn   (dmemWrEn),
    .dmemRdEn   (dmemRdEn),
    .dmemRdData (dmemRdData),
    .wb         (wb),
    .redirect   (redirect),
    .hlt        (hlt)
  );

endmodule

`default_nettype wire

//--- logic/cpuCore_config.svh
`ifndef CPUCORE_CONFIG_SVH
`define CPUCORE_CONFIG_SVH

//////////////////////////////////////////////////
// Core sizing
//////////////////////////////////////////////////

// Data word, also the width of both memory addresses
`define CPU_DATA_W 16

// Register file geometry
`define CPU_REG_CNT 16    // R0..R15
`define CPU_REG_AW 4      // Enough to index CPU_REG_CNT

// Return address register written by JAL
`define CPU_LINK_REG 15

`endif

//--- logic/cpuPkg.sv
`default_nettype none

`include "cpuCore_config.svh"

package cpuPkg;

  // Top nibble of the instruction word
  typedef enum logic [3:0] {
    opAdd = 4'h0,
    opSub = 4'h1,
    opAnd = 4'h2,
    opNor = 4'h3,
    opLlb = 4'h4,
    opNop = 4'h7,
    opLw  = 4'h8,
    opSw  = 4'h9,
    opB   = 4'hC,
    opJal = 4'hD,
    opJr  = 4'hE,
    opHlt = 4'hF
  } opcodeT;

  // Branch condition, bits 11..9 of B
  typedef enum logic [2:0] {
    condNe, condEq, condGt, condLt, condGe, condLe, condOv, condAlways
  } condT;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flagsT;

  // Decoded control, carried down the pipe
  typedef struct packed {
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic useImm;     // ALU operand B from the immediate
    logic setZn;
    logic setV;
    logic branch;
    logic jumpAL;
    logic jumpR;
    logic halt;
  } ctrlT;

  typedef struct packed {
    logic [`CPU_DATA_W-1:0] instr;
    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] pcInc;
  } ifIdT;

  typedef struct packed {
    opcodeT                 opcode;
    ctrlT                   ctrl;
    condT                   cond;
    logic [`CPU_DATA_W-1:0] opA;
    logic [`CPU_DATA_W-1:0] opB;
    logic [`CPU_DATA_W-1:0] storeData;
    logic [`CPU_DATA_W-1:0] imm;        // imm8 for LLB, imm4 for LW/SW
    logic [`CPU_DATA_W-1:0] offset;     // Branch or jump displacement
    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] pcInc;
    logic [`CPU_REG_AW-1:0] destAddr;
  } idExT;

  typedef struct packed {
    ctrlT                   ctrl;
    condT                   cond;
    flagsT                  flags;      // Flags seen by a branch
    logic [`CPU_DATA_W-1:0] aluRes;
    logic [`CPU_DATA_W-1:0] storeData;
    logic [`CPU_DATA_W-1:0] target;
    logic [`CPU_DATA_W-1:0] pcInc;
    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_REG_AW-1:0] destAddr;
  } exMemT;

  typedef struct packed {
    logic                   en;
    logic [`CPU_REG_AW-1:0] addr;
    logic [`CPU_DATA_W-1:0] data;
  } wbT;

  typedef struct packed {
    logic                   taken;
    logic [`CPU_DATA_W-1:0] target;
    logic                   halt;
  } redirectT;

endpackage

`default_nettype wire

//--- logic/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuCore_config.svh"

module decodeStage import cpuPkg::*; (
  input  logic clk,
  input  logic arstN,
  input  ifIdT ifId,
  input  wbT   wb,
  output idExT idEx
);

  opcodeT                 opcode;
  ctrlT                   ctrl;
  idExT                   idExD;
  logic [`CPU_REG_AW-1:0] rdAddrA;
  logic [`CPU_REG_AW-1:0] rdAddrB;
  logic [`CPU_DATA_W-1:0] rdDataA;
  logic [`CPU_DATA_W-1:0] rdDataB;
  logic [`CPU_DATA_W-1:0] imm8;
  logic [`CPU_DATA_W-1:0] imm4;
  logic [`CPU_DATA_W-1:0] off9;
  logic [`CPU_DATA_W-1:0] off12;

  assign opcode = opcodeT'(ifId.instr[15:12]);

  //////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////
  always_comb begin
    ctrl = '0;
    case (opcode)
      opAdd, opSub: begin
        ctrl.regWrite = 1'b1;
        ctrl.setZn    = 1'b1;
        ctrl.setV     = 1'b1;           // Only arithmetic touches V
      end
      opAnd, opNor: begin
        ctrl.regWrite = 1'b1;
        ctrl.setZn    = 1'b1;
      end
      opLlb: begin
        ctrl.regWrite = 1'b1;
        ctrl.useImm   = 1'b1;
      end
      opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.useImm   = 1'b1;
      end
      opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.useImm   = 1'b1;
      end
      opB:     ctrl.branch = 1'b1;
      opJal: begin
        ctrl.regWrite = 1'b1;           // Link into R15
        ctrl.jumpAL   = 1'b1;
      end
      opJr:    ctrl.jumpR = 1'b1;
      opHlt:   ctrl.halt  = 1'b1;
      default: ctrl = '0;               // NOP and unused codes
    endcase
  end

  // SW reads its data register through port B
  assign rdAddrA = ifId.instr[7:4];
  assign rdAddrB = (opcode == opSw) ? ifId.instr[11:8] : ifId.instr[3:0];

  regFile uRegFile (
    .clk     (clk),
    .arstN   (arstN),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wb      (wb)
  );

  // Sign extension of the immediate fields
  assign imm8  = {{(`CPU_DATA_W-8){ifId.instr[7]}}, ifId.instr[7:0]};
  assign imm4  = {{(`CPU_DATA_W-4){ifId.instr[3]}}, ifId.instr[3:0]};
  assign off9  = {{(`CPU_DATA_W-9){ifId.instr[8]}}, ifId.instr[8:0]};
  assign off12 = {{(`CPU_DATA_W-12){ifId.instr[11]}}, ifId.instr[11:0]};

  always_comb begin
    idExD.opcode    = opcode;
    idExD.ctrl      = ctrl;
    idExD.cond      = condT'(ifId.instr[11:9]);
    idExD.opA       = rdDataA;
    idExD.opB       = rdDataB;
    idExD.storeData = rdDataB;
    idExD.imm       = (opcode == opLlb) ? imm8 : imm4;
    idExD.offset    = ctrl.jumpAL ? off12 : off9;
    idExD.pc        = ifId.pc;
    idExD.pcInc     = ifId.pcInc;
    idExD.destAddr  = ctrl.jumpAL ? `CPU_REG_AW'(`CPU_LINK_REG) : ifId.instr[11:8];
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx <= '0;                       // All control low, a bubble
    end else begin
      idEx <= idExD;
    end
  end

endmodule

`default_nettype wire

//--- logic/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuCore_config.svh"

module executeStage import cpuPkg::*; (
  input  logic  clk,
  input  logic  arstN,
  input  idExT  idEx,
  output exMemT exMem
);

  localparam int Msb = `CPU_DATA_W - 1;

  logic [`CPU_DATA_W-1:0] aluB;
  logic [`CPU_DATA_W-1:0] aluRes;
  logic                   vAdd;
  logic                   vSub;
  flagsT                  flagsQ;
  flagsT                  flagsD;

  assign aluB = idEx.ctrl.useImm ? idEx.imm : idEx.opB;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  always_comb begin
    case (idEx.opcode)
      opAdd:   aluRes = idEx.opA + aluB;
      opSub:   aluRes = idEx.opA - aluB;
      opAnd:   aluRes = idEx.opA & aluB;
      opNor:   aluRes = ~(idEx.opA | aluB);
      opLlb:   aluRes = aluB;             // Sign-extended imm8
      opJr:    aluRes = idEx.opA;         // Jump target rides the result
      default: aluRes = idEx.opA + aluB;  // LW/SW address rs+imm4
    endcase
  end

  // Signed overflow, wraps on the result
  assign vAdd = (idEx.opA[Msb] == aluB[Msb]) && (aluRes[Msb] != idEx.opA[Msb]);
  assign vSub = (idEx.opA[Msb] != aluB[Msb]) && (aluRes[Msb] != idEx.opA[Msb]);

  always_comb begin
    flagsD = flagsQ;                      // Hold unless this op sets them
    if (idEx.ctrl.setZn) begin
      flagsD.z = (aluRes == '0);
      flagsD.n = aluRes[Msb];
    end
    if (idEx.ctrl.setV) begin
      flagsD.v = (idEx.opcode == opSub) ? vSub : vAdd;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagsQ <= '0;
      exMem  <= '0;
    end else begin
      flagsQ          <= flagsD;
      exMem.ctrl      <= idEx.ctrl;
      exMem.cond      <= idEx.cond;
      exMem.flags     <= flagsQ;          // Flags of earlier instructions only
      exMem.aluRes    <= aluRes;
      exMem.storeData <= idEx.storeData;
      exMem.target    <= idEx.pcInc + idEx.offset;  // pc+1+offset
      exMem.pcInc     <= idEx.pcInc;
      exMem.pc        <= idEx.pc;
      exMem.destAddr  <= idEx.destAddr;
    end
  end

endmodule

`default_nettype wire

//--- logic/fetchStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuCore_config.svh"

module fetchStage import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   arstN,
  input  redirectT               redirect,
  output logic [`CPU_DATA_W-1:0] imemAddr,
  input  logic [`CPU_DATA_W-1:0] imemData,
  output ifIdT                   ifId,
  output logic [`CPU_DATA_W-1:0] pc
);

  logic [`CPU_DATA_W-1:0] pcInc;
  logic [`CPU_DATA_W-1:0] pcNext;

  assign pcInc    = pc + 1'b1;
  assign imemAddr = pc;         // Async read, word back this cycle

  // Redirect wins, halt holds, else step
  always_comb begin
    if (redirect.taken) begin
      pcNext = redirect.target;
    end else if (redirect.halt) begin
      pcNext = pc;
    end else begin
      pcNext = pcInc;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc   <= '0;
      ifId <= '{instr: {opNop, {(`CPU_DATA_W-4){1'b0}}}, pc: '0, pcInc: '0};  // NOP bubble
    end else begin
      pc   <= pcNext;
      ifId <= '{instr: imemData, pc: pc, pcInc: pcInc};
    end
  end

endmodule

`default_nettype wire

//--- logic/memStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuCore_config.svh"

module memStage import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   arstN,
  input  exMemT                  exMem,
  output logic [`CPU_DATA_W-1:0] dmemAddr,
  output logic [`CPU_DATA_W-1:0] dmemWrData,
  output logic                   dmemWrEn,
  output logic                   dmemRdEn,
  input  logic [`CPU_DATA_W-1:0] dmemRdData,
  output wbT                     wb,
  output redirectT               redirect,
  output logic                   hlt
);

  logic haltQ;      // Sticky until reset
  logic haltNow;
  logic condMet;
  logic branchTaken;

  assign haltNow = exMem.ctrl.halt;
  assign hlt     = haltNow | haltQ;

  always_comb begin
    case (exMem.cond)
      condNe:  condMet = !exMem.flags.z;
      condEq:  condMet = exMem.flags.z;
      condGt:  condMet = !exMem.flags.z && !exMem.flags.n;
      condLt:  condMet = exMem.flags.n;
      condGe:  condMet = !exMem.flags.n;
      condLe:  condMet = exMem.flags.z || exMem.flags.n;
      condOv:  condMet = exMem.flags.v;
      default: condMet = 1'b1;            // Always
    endcase
  end

  assign branchTaken = exMem.ctrl.branch & condMet;

  // First HLT pulls pc back to its own address, then fetch holds
  always_comb begin
    redirect.taken  = !haltQ && (haltNow || branchTaken ||
                                 exMem.ctrl.jumpAL || exMem.ctrl.jumpR);
    redirect.target = haltNow          ? exMem.pc :
                      exMem.ctrl.jumpR ? exMem.aluRes : exMem.target;
    redirect.halt   = hlt;
  end

  //////////////////////////////////////////////////
  // Data memory bus and write-back
  //////////////////////////////////////////////////
  assign dmemAddr   = exMem.aluRes;
  assign dmemWrData = exMem.storeData;
  assign dmemWrEn   = exMem.ctrl.memWrite & !hlt;
  assign dmemRdEn   = exMem.ctrl.memRead;

  always_comb begin
    wb.en   = exMem.ctrl.regWrite & !hlt;
    wb.addr = exMem.destAddr;
    wb.data = exMem.ctrl.jumpAL  ? exMem.pcInc :    // Link value
              exMem.ctrl.memRead ? dmemRdData : exMem.aluRes;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      haltQ <= 1'b0;
    end else if (haltNow) begin
      haltQ <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpuCore_config.svh"

module regFile import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`CPU_REG_AW-1:0] rdAddrA,
  input  logic [`CPU_REG_AW-1:0] rdAddrB,
  output logic [`CPU_DATA_W-1:0] rdDataA,
  output logic [`CPU_DATA_W-1:0] rdDataB,
  input  wbT                     wb
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_REG_CNT];

  // R0 hardwired to zero
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regs <= '{default: '0};
    end else if (wb.en && (wb.addr != '0)) begin
      regs[wb.addr] <= wb.data;         // Seen by decode next cycle
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/cpuPkg.sv
logic/regFile.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memStage.sv
logic/cpuCore.sv
dv/cpuCoreTb.sv
